/* Bender.yml */
package:
  name: obj_engine

sources:
  - include_dirs:
      - common
    files:
      - common/obj_sprite_pkg.sv
      - common/obj_draw_pkg.sv
      - obj_scan/obj_scanner.sv
      - obj_scan/obj_priority_queue.sv
      - obj_draw/obj_tile_renderer.sv
      - source/obj_line_buffer.sv
      - source/obj_engine.sv
  - target: test
    files:
      - test/tb_obj_engine.sv

/* common/obj_draw_pkg.sv */
`default_nettype none

package obj_draw_pkg;

    // graphics ROM request, held while gfx_cs is high
    typedef struct packed {
        logic [14:0] tile;
        logic [15:0] offset;  // byte offset of the 8 pixel slice inside the tile
        logic [3:0]  bank;
    } gfx_req_t;

    typedef struct packed {
        logic [3:0] prio;
        logic [6:0] palette;
        logic [3:0] code;     // 0 is transparent
    } obj_pixel_t;

    typedef struct packed {
        logic       we;
        logic [8:0] addr;
        obj_pixel_t pixel;
    } line_wr_t;

endpackage

`default_nettype wire

/* common/obj_settings.svh */
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// visible pixels on one line
`define OBJ_SCREEN_W 320

`define OBJ_SPRITE_COUNT 256  // entries in sprite RAM
`define OBJ_PRIORITIES 16
`define OBJ_QUEUE_DEPTH 32    // per priority level, later sprites are dropped

// positions above these limits sit 512 lower, so sprites can enter from the edge
`define OBJ_Y_WRAP 384
`define OBJ_X_WRAP 384

`endif

/* common/obj_sprite_pkg.sv */
`default_nettype none

package obj_sprite_pkg;

    // word 0 of a sprite entry
    typedef struct packed {
        logic       active;
        logic       multi;    // chained sprite flag, ignored
        logic       yflip;    // ignored
        logic       xflip;
        logic [3:0] prio;
        logic [5:0] palette;
        logic [1:0] bank_hi;
    } spr_word0_t;

    typedef struct packed {
        logic        bank_lo;
        logic [14:0] tile;
    } spr_word1_t;

    // words 2 (x) and 3 (y) share one layout
    typedef struct packed {
        logic [8:0] pos;
        logic [2:0] rsvd;
        logic [3:0] size;   // tiles minus one
    } spr_pos_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] prio;
        logic [7:0] index;
    } queue_push_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] index;
    } queue_head_t;

endpackage

`default_nettype wire

/* obj_draw/obj_tile_renderer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "obj_settings.svh"

module obj_tile_renderer import obj_sprite_pkg::*, obj_draw_pkg::*; (
    input  logic               clk96_i,
    input  logic               reset96_i,
    input  logic               line_start_i,
    input  logic               scan_done_i,
    input  queue_head_t        head_i,
    output logic               pop_o,
    input  logic [8:0]         vrender_i,
    input  logic signed [12:0] scroll_x_i,
    input  logic signed [12:0] scroll_y_i,
    output logic [9:0]         spr_b_addr_o,
    input  logic [15:0]        spr_b_data_i,
    output logic               gfx_cs_o,
    output gfx_req_t           gfx_req_o,
    input  logic               gfx_ok_i,
    input  logic [31:0]        gfx_data_i,
    output line_wr_t           line_wr_o
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_FETCH = 3'd1;  // four attribute words
    localparam logic [2:0] S_CALC  = 3'd2;
    localparam logic [2:0] S_REQ   = 3'd3;
    localparam logic [2:0] S_WAIT  = 3'd4;
    localparam logic [2:0] S_DRAW  = 3'd5;

    logic [2:0]         state_q;
    logic [2:0]         wcnt_q;
    logic [4:0]         col_q;    // tile column inside the sprite
    logic [2:0]         px_q;
    logic               cut_q;    // line restarted while the ROM was busy
    logic               cs_q;
    logic               we_q;
    logic [7:0]         idx_q;
    spr_word0_t         w0_q;
    spr_word1_t         w1_q;
    spr_pos_t           w2_q;
    spr_pos_t           w3_q;
    logic signed [10:0] x_pos_q;
    logic [6:0]         row_q;
    logic [31:0]        slice_q;
    gfx_req_t           req_q;
    logic [8:0]         wr_addr_q;
    obj_pixel_t         wr_pix_q;

    logic [8:0]         x_mod;
    logic [8:0]         y_mod;
    logic signed [10:0] x_wrap;
    logic signed [10:0] y_wrap;
    logic [10:0]        row_full;
    logic [15:0]        tile_off;
    logic signed [10:0] x_pix;
    logic [2:0]         nib;
    logic [3:0]         code;
    logic               pix_on;

    always_comb begin
        x_mod    = w2_q.pos + scroll_x_i[8:0];
        y_mod    = w3_q.pos + scroll_y_i[8:0];
        x_wrap   = {2'b00, x_mod} - ((x_mod > `OBJ_X_WRAP) ? 11'd512 : 11'd0);
        y_wrap   = {2'b00, y_mod} - ((y_mod > `OBJ_Y_WRAP) ? 11'd512 : 11'd0);
        row_full = {2'b00, vrender_i} - y_wrap;
        // tile rows are (xsize+1) tiles of 32 bytes, one slice row is 4 bytes
        tile_off = 16'(row_q[6:3]) * ((16'(w2_q.size) + 16'd1) << 5)
                 + 16'(row_q[2:0]) * 16'd4 + 16'(col_q) * 16'd32;
        x_pix    = x_pos_q + 11'({col_q, px_q});
        nib      = px_q ^ {3{w0_q.xflip}};  // reversed slice under xflip
        code     = slice_q[{nib, 2'b00} +: 4];
        pix_on   = (code != 4'd0) && (x_pix >= 0) && (x_pix < `OBJ_SCREEN_W);
    end

    assign pop_o        = (state_q == S_IDLE) && scan_done_i && head_i.valid;
    assign spr_b_addr_o = {idx_q, wcnt_q[1:0]};
    assign gfx_cs_o     = cs_q;
    assign gfx_req_o    = req_q;
    assign line_wr_o    = '{we: we_q, addr: wr_addr_q, pixel: wr_pix_q};

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            state_q <= S_IDLE;
            wcnt_q  <= 3'd0;
            col_q   <= 5'd0;
            px_q    <= 3'd0;
            cut_q   <= 1'b0;
            cs_q    <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            we_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (pop_o) begin
                        state_q <= S_FETCH;
                        wcnt_q  <= 3'd0;
                    end
                end
                S_FETCH: begin
                    wcnt_q <= wcnt_q + 3'd1;
                    if (wcnt_q == 3'd4)
                        state_q <= S_CALC;
                end
                S_CALC: begin
                    col_q   <= 5'd0;
                    state_q <= S_REQ;
                end
                S_REQ: begin
                    if (col_q > {1'b0, w2_q.size}) begin
                        state_q <= S_IDLE;
                    end else if (!gfx_ok_i) begin  // previous cycle fully closed
                        cs_q    <= 1'b1;
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (gfx_ok_i) begin
                        cs_q    <= 1'b0;
                        px_q    <= 3'd0;
                        cut_q   <= 1'b0;
                        state_q <= cut_q ? S_IDLE : S_DRAW;
                    end
                end
                S_DRAW: begin
                    we_q <= pix_on;
                    px_q <= px_q + 3'd1;
                    if (px_q == 3'd7) begin
                        col_q   <= col_q + 5'd1;
                        state_q <= S_REQ;
                    end
                end
                default: state_q <= S_IDLE;
            endcase

            // a new line cuts the sprite off, but an open ROM cycle runs to its end
            if (line_start_i || cut_q) begin
                if (state_q != S_WAIT) begin
                    state_q <= S_IDLE;
                    cs_q    <= 1'b0;
                    we_q    <= 1'b0;
                    cut_q   <= 1'b0;
                end else if (line_start_i || !gfx_ok_i) begin
                    cut_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk96_i) begin
        if (pop_o)
            idx_q <= head_i.index;
        if (state_q == S_FETCH) begin
            case (wcnt_q)
                3'd1: w0_q <= spr_b_data_i;
                3'd2: w1_q <= spr_b_data_i;
                3'd3: w2_q <= spr_b_data_i;
                3'd4: w3_q <= spr_b_data_i;
                default: ;
            endcase
        end
        if (state_q == S_CALC) begin
            x_pos_q <= x_wrap;
            row_q   <= row_full[6:0];
        end
        if (state_q == S_REQ)
            req_q <= '{tile:   w1_q.tile,
                       offset: tile_off,
                       bank:   {1'b0, w0_q.bank_hi, w1_q.bank_lo}};
        if (state_q == S_WAIT && gfx_ok_i)
            slice_q <= gfx_data_i;
        if (state_q == S_DRAW) begin
            wr_addr_q <= x_pix[8:0];
            wr_pix_q  <= '{prio: w0_q.prio, palette: {1'b0, w0_q.palette}, code: code};
        end
    end

endmodule

`default_nettype wire

/* obj_engine.f */
+incdir+common
common/obj_sprite_pkg.sv
common/obj_draw_pkg.sv
obj_scan/obj_scanner.sv
obj_scan/obj_priority_queue.sv
obj_draw/obj_tile_renderer.sv
source/obj_line_buffer.sv
source/obj_engine.sv
test/tb_obj_engine.sv

/* obj_scan/obj_priority_queue.sv */
`timescale 1ns/1ps
`default_nettype none
`include "obj_settings.svh"

module obj_priority_queue import obj_sprite_pkg::*; (
    input  logic        clk96_i,
    input  logic        reset96_i,
    input  logic        clear_i,
    input  queue_push_t push_i,
    input  logic        pop_i,
    output queue_head_t head_o
);

    localparam int PW = $clog2(`OBJ_PRIORITIES);
    localparam int QW = $clog2(`OBJ_QUEUE_DEPTH);
    localparam logic [QW:0] DEPTH = `OBJ_QUEUE_DEPTH;

    logic [7:0]                 slot_q [`OBJ_PRIORITIES][`OBJ_QUEUE_DEPTH];
    logic [QW:0]                count_q [`OBJ_PRIORITIES];
    logic [QW-1:0]              rd_ptr_q;  // position inside the current level
    logic [`OBJ_PRIORITIES-1:0] mask_q;    // levels that still hold sprites
    logic [PW-1:0]              cur_pri;
    logic                       push_ok;

    // lowest non-empty level goes first
    always_comb begin
        cur_pri = '0;
        for (int p = `OBJ_PRIORITIES - 1; p >= 0; p--) begin
            if (mask_q[p])
                cur_pri = PW'(p);
        end
    end

    assign head_o  = '{valid: |mask_q, index: slot_q[cur_pri][rd_ptr_q]};
    assign push_ok = push_i.valid && (count_q[push_i.prio] != DEPTH);

    always_ff @(posedge clk96_i) begin
        if (push_ok)
            slot_q[push_i.prio][count_q[push_i.prio][QW-1:0]] <= push_i.index;
    end

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            for (int p = 0; p < `OBJ_PRIORITIES; p++)
                count_q[p] <= '0;
            rd_ptr_q <= '0;
            mask_q   <= '0;
        end else if (clear_i) begin
            for (int p = 0; p < `OBJ_PRIORITIES; p++)
                count_q[p] <= '0;
            rd_ptr_q <= '0;
            mask_q   <= '0;
        end else begin
            if (push_ok) begin
                count_q[push_i.prio] <= count_q[push_i.prio] + 1'b1;
                mask_q[push_i.prio]  <= 1'b1;
            end
            if (pop_i && head_o.valid) begin
                if ({1'b0, rd_ptr_q} + 1'b1 == count_q[cur_pri]) begin
                    mask_q[cur_pri] <= 1'b0;  // level drained, move up
                    rd_ptr_q        <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* obj_scan/obj_scanner.sv */
`timescale 1ns/1ps
`default_nettype none
`include "obj_settings.svh"

module obj_scanner import obj_sprite_pkg::*; (
    input  logic               clk96_i,
    input  logic               reset96_i,
    input  logic               hb_i,
    input  logic               vb_i,
    input  logic [8:0]         vrender_i,
    input  logic signed [12:0] scroll_y_i,
    output logic [9:0]         spr_a_addr_o,
    input  logic [15:0]        spr_a_data_i,
    output queue_push_t        push_o,
    output logic               line_start_o,
    output logic               scan_done_o
);

    logic               hb_q;
    logic               start_q;
    logic               done_q;
    logic [7:0]         idx_q;
    logic [1:0]         phase_q;  // 0 addr word 0, 1 addr word 3, 2 test
    spr_word0_t         w0_q;
    spr_pos_t           w3;
    logic               go;
    logic [8:0]         y_mod;
    logic signed [10:0] y_pos;
    logic signed [10:0] y_end;
    logic signed [10:0] v;
    logic               hit;

    // lines start on the falling edge of hblank, only line 0 starts inside vblank
    assign go = hb_q & ~hb_i & (~vb_i | (vrender_i == 9'd0));

    assign spr_a_addr_o = {idx_q, (phase_q == 2'd0) ? 2'd0 : 2'd3};
    assign w3 = spr_a_data_i;  // word 3 is on the bus in phase 2

    always_comb begin
        y_mod = w3.pos + scroll_y_i[8:0];
        y_pos = {2'b00, y_mod} - ((y_mod > `OBJ_Y_WRAP) ? 11'd512 : 11'd0);
        y_end = y_pos + 11'(({7'd0, w3.size} + 11'd1) << 3);
        v     = {2'b00, vrender_i};
        hit   = w0_q.active && (v >= y_pos) && (v < y_end);
    end

    assign push_o = '{valid: !done_q && (phase_q == 2'd2) && hit,
                      prio:  w0_q.prio,
                      index: idx_q};
    assign line_start_o = start_q;
    assign scan_done_o  = done_q;

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            hb_q    <= 1'b0;
            start_q <= 1'b0;
            done_q  <= 1'b1;
            idx_q   <= 8'd0;
            phase_q <= 2'd0;
        end else begin
            hb_q    <= hb_i;
            start_q <= go;
            if (go) begin
                done_q  <= 1'b0;
                idx_q   <= 8'd0;
                phase_q <= 2'd0;
            end else if (!done_q) begin
                if (phase_q == 2'd2) begin
                    phase_q <= 2'd0;
                    idx_q   <= idx_q + 8'd1;
                    if (idx_q == 8'(`OBJ_SPRITE_COUNT - 1))
                        done_q <= 1'b1;  // last push lands in the queue on this edge
                end else begin
                    phase_q <= phase_q + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk96_i) begin
        if (phase_q == 2'd1)
            w0_q <= spr_a_data_i;
    end

endmodule

`default_nettype wire

/* source/obj_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module obj_engine import obj_sprite_pkg::*, obj_draw_pkg::*; (
    input  logic               clk96_i,
    input  logic               reset96_i,
    input  logic               hb_i,
    input  logic               vb_i,
    input  logic [8:0]         vrender_i,
    input  logic [8:0]         h_i,
    input  logic               active_i,
    input  logic               pixel_cen_i,
    input  logic signed [12:0] scroll_x_i,
    input  logic signed [12:0] scroll_y_i,
    output logic [9:0]         spr_a_addr_o,
    input  logic [15:0]        spr_a_data_i,
    output logic [9:0]         spr_b_addr_o,
    input  logic [15:0]        spr_b_data_i,
    output logic               gfx_cs_o,
    output gfx_req_t           gfx_req_o,
    input  logic               gfx_ok_i,
    input  logic [31:0]        gfx_data_i,
    output obj_pixel_t         obj_pixel_o,
    output logic               scan_done_o
);

    queue_push_t push;
    queue_head_t head;
    line_wr_t    line_wr;
    logic        line_start;
    logic        pop;

    obj_scanner u_scanner (
        .clk96_i     (clk96_i),
        .reset96_i   (reset96_i),
        .hb_i        (hb_i),
        .vb_i        (vb_i),
        .vrender_i   (vrender_i),
        .scroll_y_i  (scroll_y_i),
        .spr_a_addr_o(spr_a_addr_o),
        .spr_a_data_i(spr_a_data_i),
        .push_o      (push),
        .line_start_o(line_start),
        .scan_done_o (scan_done_o)
    );

    obj_priority_queue u_queue (
        .clk96_i  (clk96_i),
        .reset96_i(reset96_i),
        .clear_i  (line_start),
        .push_i   (push),
        .pop_i    (pop),
        .head_o   (head)
    );

    obj_tile_renderer u_renderer (
        .clk96_i     (clk96_i),
        .reset96_i   (reset96_i),
        .line_start_i(line_start),
        .scan_done_i (scan_done_o),
        .head_i      (head),
        .pop_o       (pop),
        .vrender_i   (vrender_i),
        .scroll_x_i  (scroll_x_i),
        .scroll_y_i  (scroll_y_i),
        .spr_b_addr_o(spr_b_addr_o),
        .spr_b_data_i(spr_b_data_i),
        .gfx_cs_o    (gfx_cs_o),
        .gfx_req_o   (gfx_req_o),
        .gfx_ok_i    (gfx_ok_i),
        .gfx_data_i  (gfx_data_i),
        .line_wr_o   (line_wr)
    );

    obj_line_buffer u_line_buffer (
        .clk96_i    (clk96_i),
        .reset96_i  (reset96_i),
        .hb_i       (hb_i),
        .pixel_cen_i(pixel_cen_i),
        .active_i   (active_i),
        .h_i        (h_i),
        .wr_i       (line_wr),
        .obj_pixel_o(obj_pixel_o)
    );

endmodule

`default_nettype wire

/* source/obj_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "obj_settings.svh"

module obj_line_buffer import obj_draw_pkg::*; (
    input  logic       clk96_i,
    input  logic       reset96_i,
    input  logic       hb_i,
    input  logic       pixel_cen_i,
    input  logic       active_i,
    input  logic [8:0] h_i,
    input  line_wr_t   wr_i,
    output obj_pixel_t obj_pixel_o
);

    logic       hb_q;
    logic       wr_sel_q;  // half being drawn, the other half is on screen
    logic [8:0] clr_q;     // sweeps both halves once after reset
    logic       clearing;
    logic       rd_en;
    obj_pixel_t rd_pix [2];

    assign clearing = clr_q < `OBJ_SCREEN_W;
    assign rd_en    = pixel_cen_i & active_i & (h_i < `OBJ_SCREEN_W);

    for (genvar g = 0; g < 2; g++) begin : g_half
        obj_pixel_t mem [`OBJ_SCREEN_W];
        logic       is_wr;

        assign is_wr = (wr_sel_q == 1'(g));

        always_ff @(posedge clk96_i) begin
            if (clearing)
                mem[clr_q] <= '0;
            else if (is_wr && wr_i.we)
                mem[wr_i.addr] <= wr_i.pixel;
            else if (!is_wr && rd_en)
                mem[h_i] <= '0;  // shown once, ready for the line after next
        end

        assign rd_pix[g] = mem[h_i];
    end

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            hb_q        <= 1'b0;
            wr_sel_q    <= 1'b0;
            clr_q       <= 9'd0;
            obj_pixel_o <= '0;
        end else begin
            hb_q <= hb_i;
            if (hb_q && !hb_i)
                wr_sel_q <= ~wr_sel_q;
            if (clearing)
                clr_q <= clr_q + 9'd1;
            // halves hold no pixels until the sweep is over
            if (pixel_cen_i && active_i)
                obj_pixel_o <= (h_i < `OBJ_SCREEN_W && !clearing) ? rd_pix[~wr_sel_q] : '0;
        end
    end

endmodule

`default_nettype wire

/* test/obj_input.txt */
// first word: test count. per test: sprites scroll_x scroll_y line pixels,
// then per sprite: index w0 w1 w2 w3, then expected pixel pairs: x value
0004
// one 2x2 tile sprite, scrolled, row 10
0001 0004 0002 0034 000D
0005 8328 0010 3201 1401
0068 18A8 0069 18A9 006A 18AA 006C 18AC 006D 18AD 006E 18AE 006F 18AF
0070 18A8 0072 18AA 0073 18AB 0074 18AC 0075 18AD 0077 18AF
// clipping at both edges, inactive sprite, sprite off the line
0004 1FFC 0000 0014 0006
0000 8104 0001 0000 0A00
0001 0104 0000 6400 0A00
0002 8104 0000 6400 3200
0003 8208 0000 A000 0A00
0000 0814 0002 0816 0003 0817 013D 1021 013E 1022 013F 1023
// overlap by priority, then equal priority by index
0004 0000 0000 001E 000F
0007 850C 0000 1900 0F00
0002 8910 0000 1A00 0F00
000A 8604 0000 2800 0F00
000C 8608 0000 2800 0F00
0033 2831 0034 2832 0035 4841 0036 4842 0037 4843 0038 4844 0039 2837 003A 4846
003B 4847 0051 3021 0052 3022 0053 3023 0054 3024 0056 3026 0057 3027
// xflip on row 1
0001 0000 0000 003D 0006
0014 9414 0000 6400 1E00
00C8 205B 00CA 2059 00CB 2058 00CC 2057 00CD 2056 00CF 2054

/* test/tb_obj_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_obj_engine import obj_draw_pkg::*; ();

    logic               clk96 = 1'b0;
    logic               reset96;
    logic               hb;
    logic               vb;
    logic [8:0]         vrender;
    logic [8:0]         h;
    logic               active;
    logic               pixel_cen;
    logic signed [12:0] scroll_x;
    logic signed [12:0] scroll_y;
    logic [9:0]         spr_a_addr;
    logic [15:0]        spr_a_data;
    logic [9:0]         spr_b_addr;
    logic [15:0]        spr_b_data;
    logic               gfx_cs;
    gfx_req_t           gfx_req;
    logic               gfx_ok;
    logic [31:0]        gfx_data;
    obj_pixel_t         obj_pixel;
    logic               scan_done;

    logic [15:0] spr_ram [1024];
    logic [15:0] stim [256];   // whole input file
    logic [14:0] expect_px [320];
    logic [1:0]  div;
    logic [1:0]  rom_cnt;
    logic        prev_cs;

    obj_engine dut_i (
        .clk96_i(clk96), .reset96_i(reset96), .hb_i(hb), .vb_i(vb),
        .vrender_i(vrender), .h_i(h), .active_i(active), .pixel_cen_i(pixel_cen),
        .scroll_x_i(scroll_x), .scroll_y_i(scroll_y),
        .spr_a_addr_o(spr_a_addr), .spr_a_data_i(spr_a_data),
        .spr_b_addr_o(spr_b_addr), .spr_b_data_i(spr_b_data),
        .gfx_cs_o(gfx_cs), .gfx_req_o(gfx_req), .gfx_ok_i(gfx_ok), .gfx_data_i(gfx_data),
        .obj_pixel_o(obj_pixel), .scan_done_o(scan_done)
    );

    always #20 clk96 = ~clk96;

    // sprite RAM, one cycle read latency on both ports
    always @(posedge clk96) begin
        spr_a_data <= spr_ram[spr_a_addr];
        spr_b_data <= spr_ram[spr_b_addr];
    end

    // 512 positions per line, h moves two cycles before the pixel strobe
    always @(negedge clk96) begin
        div = div + 2'd1;
        if (div == 2'd0)
            h = h + 9'd1;
        hb        = (h >= 9'd320);
        active    = (h < 9'd320);
        pixel_cen = (div == 2'd2);
    end

    // nibble k is the low 4 bits of offset+k, zero on multiples of 5
    function automatic logic [31:0] rom_slice(input logic [15:0] offset);
        logic [31:0] d;
        logic [15:0] v;
        d = '0;
        for (int k = 0; k < 8; k++) begin
            v = offset + 16'(k);
            d[4*k +: 4] = (v % 5 == 0) ? 4'd0 : v[3:0];
        end
        return d;
    endfunction

    // graphics ROM with a handshake monitor
    always @(negedge clk96) begin
        if (!reset96) begin
            if (prev_cs && !gfx_cs)
                assert (gfx_ok) else begin
                    $display("** FAIL **");
                    $fatal(1, "gfx_cs_o fell at %0t before gfx_ok_i rose", $time);
                end
            if (!prev_cs && gfx_cs)
                assert (!gfx_ok) else begin
                    $display("** FAIL **");
                    $fatal(1, "gfx_cs_o rose at %0t while gfx_ok_i was still high", $time);
                end
        end
        prev_cs = gfx_cs;
        if (gfx_cs && !gfx_ok) begin
            rom_cnt = rom_cnt + 2'd1;
            if (rom_cnt == 2'd3) begin
                gfx_ok   = 1'b1;
                gfx_data = rom_slice(gfx_req.offset);
            end
        end else if (!gfx_cs) begin
            rom_cnt = 2'd0;
            gfx_ok  = 1'b0;
        end
    end

    task automatic wait_pixel(input logic [8:0] target);
        logic found;
        found = 1'b0;
        for (int n = 0; n < 4096 && !found; n++) begin
            @(posedge clk96);
            found = pixel_cen && (h == target);
        end
        assert (found) else begin
            $display("** FAIL **");
            $fatal(1, "timed out waiting for position %0d", target);
        end
    endtask

    initial begin
        int p;
        int ntests;
        reset96    = 1'b1;
        vb         = 1'b0;
        vrender    = 9'd0;
        h          = 9'd0;
        div        = 2'd0;
        hb         = 1'b0;
        active     = 1'b1;
        pixel_cen  = 1'b0;
        scroll_x   = '0;
        scroll_y   = '0;
        spr_a_data = '0;
        spr_b_data = '0;
        gfx_ok     = 1'b0;
        gfx_data   = '0;
        rom_cnt    = 2'd0;
        prev_cs    = 1'b0;
        foreach (spr_ram[i]) spr_ram[i] = 16'h0000;
        $readmemh("test/obj_input.txt", stim);
        repeat (16) @(posedge clk96);
        @(negedge clk96);
        reset96 = 1'b0;
        @(negedge clk96);
        assert (obj_pixel == '0 && !gfx_cs && scan_done) else begin
            $display("** FAIL **");
            $fatal(1, {"FAILED t=%0t obj_pixel_o=%h gfx_cs_o=%b scan_done_o=%b after reset,",
                       " expected 0 0 1"},
                   $time, obj_pixel, gfx_cs, scan_done);
        end
        ntests = stim[0];
        p = 1;
        for (int t = 0; t < ntests; t++) begin
            wait_pixel(9'd400);  // blanking before the rendered line
            @(negedge clk96);
            foreach (spr_ram[i]) spr_ram[i] = 16'h0000;
            foreach (expect_px[i]) expect_px[i] = '0;
            scroll_x = stim[p+1][12:0];
            scroll_y = stim[p+2][12:0];
            vrender  = stim[p+3][8:0];
            for (int s = 0; s < stim[p]; s++)
                for (int k = 0; k < 4; k++)
                    spr_ram[stim[p+5+5*s]*4 + k] = stim[p+6+5*s+k];
            for (int n = 0; n < stim[p+4]; n++)
                expect_px[stim[p+5+5*stim[p]+2*n]] = stim[p+6+5*stim[p]+2*n][14:0];
            p = p + 5 + 5*stim[p] + 2*stim[p+4];
            wait_pixel(9'd0);    // line L is rendered now
            wait_pixel(9'd400);
            for (int x = 0; x < 320; x++) begin
                wait_pixel(9'(x));
                @(negedge clk96);
                assert (obj_pixel == expect_px[x]) else begin
                    $display("** FAIL **");
                    $fatal(1, "FAILED t=%0t test %0d obj_pixel_o x=%0d got %h expected %h",
                           $time, t, x, obj_pixel, expect_px[x]);
                end
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
